//--- bench/i2c_bit_ctrl_chk.sv
// protocol checks on the bit controller ports, bound into every i2c_bit_ctrl
// checks are off while nReset is low
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl_chk (
    input wire logic clk,
    input wire logic nReset,
    input wire logic cmd_ack,
    input wire logic al,
    input wire logic scl_oen,
    input wire logic sda_oen
);

    int assert_fail_cnt = 0;    // failed assertions so far

    // ack is a single cycle pulse
    ack_pulse: assert property (@(posedge clk) disable iff (!nReset) cmd_ack |=> !cmd_ack)
        else begin
            assert_fail_cnt++;
            $error("cmd_ack high two cycles in a row");
        end

    ack_not_al: assert property (@(posedge clk) disable iff (!nReset) !(al && cmd_ack))
        else begin
            assert_fail_cnt++;
            $error("al and cmd_ack high together");
        end

    // lost bus means both lines released
    al_release: assert property (@(posedge clk) disable iff (!nReset) al |=> scl_oen && sda_oen)
        else begin
            assert_fail_cnt++;
            $error("enables not released after al");
        end

endmodule

bind i2c_bit_ctrl i2c_bit_ctrl_chk i_chk (
    .clk(clk), .nReset(nReset), .cmd_ack(cmd_ack), .al(al),
    .scl_oen(scl_oen), .sda_oen(sda_oen)
);

`default_nettype wire

//--- bench/tb_i2c_bit_ctrl.sv
// testbench for the I2C master bit controller with a wired-AND bus and a simple target model
// prescale fixed at 7, so each phase is 8 clocks unless the target stretches scl
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_bit_ctrl
    import i2c_bit_pkg::*;
;

    localparam int WAIT_MAX = 400;          // cycles per wait loop

    logic        clk = 1'b0;
    logic        nReset, ena, din;
    logic [15:0] clk_cnt;
    i2c_cmd_t    cmd;
    logic        cmd_ack, busy, al, dout, scl_oen, sda_oen;
    logic        tgt_sda;                   // target pull on sda, 0 pulls low
    logic        capture;                   // target records sda on scl rise
    logic        scl_bus, sda_bus, scl_prev;
    int          cycle_cnt, stretch_until;
    int          ack_count, al_count, err_cnt, timeout_cnt;
    integer      seed;
    logic        samples[$];                // bits the target saw

    always #5 clk = ~clk;

    // open drain lines with pull-up
    assign scl_bus = scl_oen & ~(cycle_cnt < stretch_until);
    assign sda_bus = sda_oen & tgt_sda;

    i2c_bit_ctrl #(.PRESCALE_W(16)) i_i2c_bit_ctrl (
        .clk(clk), .nReset(nReset), .ena(ena), .clk_cnt(clk_cnt), .cmd(cmd), .din(din),
        .scl_i(scl_bus), .sda_i(sda_bus), .cmd_ack(cmd_ack), .busy(busy), .al(al),
        .dout(dout), .scl_oen(scl_oen), .sda_oen(sda_oen)
    );

    // target side monitors
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        scl_prev  <= scl_bus;
        if (capture && scl_bus && !scl_prev)
            samples.push_back(sda_bus);
        if (cmd_ack)
            ack_count <= ack_count + 1;
        if (al)
            al_count <= al_count + 1;
    end

    // msb first on the wire
    function automatic logic ref_bit(input logic [7:0] data, input int idx);
        return data[7-idx];
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cmd_ack_seen(input i2c_cmd_t c, input bit seen, input bit exp);
        if (seen != exp) begin
            $display("ERROR %0t: cmd_ack for %s seen %0d, expected %0d",
                     $time, c.name(), seen, exp);
            err_cnt++;
        end
    endtask

    // issue a command and hold it until cmd_ack
    task automatic run_cmd(input i2c_cmd_t c, input logic d);
        bit seen;
        seen = 0;
        @(posedge clk);
        cmd <= c;
        din <= d;
        for (int i = 0; i < WAIT_MAX && !seen; i++) begin
            @(posedge clk);
            if (cmd_ack) begin
                seen = 1;
                cmd  <= CMD_NOP;
            end
        end
        if (!seen) begin
            $display("timed out waiting for cmd_ack on %s", c.name());
            timeout_cnt++;
            cmd <= CMD_NOP;
        end
        check_cmd_ack_seen(c, seen, 1'b1);
    endtask

    task automatic wait_idle_bus();
        int i;
        for (i = 0; i < WAIT_MAX && busy; i++)
            @(posedge clk);
        if (busy) begin
            $display("timed out waiting for busy to clear");
            timeout_cnt++;
        end
    endtask

    initial begin
        logic [7:0] wr_byte, rd_byte;
        bit         al_seen;
        int         base, acks;
        nReset = 1'b0;
        ena = 1'b1;
        clk_cnt = 16'd7;
        cmd = CMD_NOP;
        din = 1'b0;
        tgt_sda = 1'b1;
        capture = 1'b0;
        cycle_cnt = 0;
        stretch_until = 0;
        ack_count = 0;
        al_count = 0;
        err_cnt = 0;
        timeout_cnt = 0;
        seed = 32'h9b9d88f9;
        repeat (10) @(posedge clk);
        nReset <= 1'b1;

        // reset state
        @(posedge clk);
        check_bit("cmd_ack", cmd_ack, 1'b0);
        check_bit("al", al, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("scl_oen", scl_oen, 1'b1);
        check_bit("sda_oen", sda_oen, 1'b1);

        // start then stop
        run_cmd(CMD_START, 1'b0);
        check_bit("busy after start", busy, 1'b1);
        run_cmd(CMD_STOP, 1'b0);
        wait_idle_bus();
        check_bit("busy after stop", busy, 1'b0);

        ////////////////////////////////////////////////////////////////////////
        // write a random byte, target samples each bit
        ////////////////////////////////////////////////////////////////////////
        wr_byte = 8'($random(seed));
        run_cmd(CMD_START, 1'b0);
        base = samples.size();
        capture <= 1'b1;
        for (int i = 0; i < 8; i++)
            run_cmd(CMD_WRITE, ref_bit(wr_byte, i));
        capture <= 1'b0;
        run_cmd(CMD_STOP, 1'b0);
        check_bit("write sample count", samples.size() == base + 8, 1'b1);
        for (int i = 0; i < 8 && base + i < samples.size(); i++)
            check_bit($sformatf("write bit %0d", i), samples[base+i], ref_bit(wr_byte, i));
        wait_idle_bus();

        // read a random byte driven by the target
        rd_byte = 8'($random(seed));
        run_cmd(CMD_START, 1'b0);
        for (int i = 0; i < 8; i++) begin
            tgt_sda <= rd_byte[7-i];
            run_cmd(CMD_READ, 1'b0);
            check_bit($sformatf("read bit %0d", i), dout, ref_bit(rd_byte, i));
        end
        tgt_sda <= 1'b1;                    // scl is low here
        run_cmd(CMD_STOP, 1'b0);
        wait_idle_bus();

        // clock stretch across a write of 1
        run_cmd(CMD_START, 1'b0);
        base = samples.size();
        capture <= 1'b1;
        stretch_until <= cycle_cnt + 60;    // several phases long
        run_cmd(CMD_WRITE, 1'b1);
        capture <= 1'b0;
        check_bit("stretch sample count", samples.size() == base + 1, 1'b1);
        if (samples.size() > base)
            check_bit("stretched write bit", samples[base], 1'b1);
        run_cmd(CMD_STOP, 1'b0);
        wait_idle_bus();
        check_bit("al before arbitration test", al_count == 0, 1'b1);

        ////////////////////////////////////////////////////////////////////////
        // arbitration loss on a write of 1
        ////////////////////////////////////////////////////////////////////////
        run_cmd(CMD_START, 1'b0);
        al_seen = 0;
        @(posedge clk);
        acks = ack_count;                   // start ack already counted
        cmd <= CMD_WRITE;
        din <= 1'b1;
        tgt_sda <= 1'b0;                    // other master drives 0
        for (int i = 0; i < WAIT_MAX && !al_seen; i++) begin
            @(posedge clk);
            if (al) begin
                al_seen = 1;
                cmd <= CMD_NOP;
            end
        end
        if (!al_seen) begin
            $display("timed out waiting for arbitration loss");
            timeout_cnt++;
            cmd <= CMD_NOP;
        end
        @(posedge clk);
        check_bit("scl_oen after al", scl_oen, 1'b1);
        check_bit("sda_oen after al", sda_oen, 1'b1);
        repeat (100) @(posedge clk);
        check_cmd_ack_seen(CMD_WRITE, ack_count != acks, 1'b0);
        tgt_sda <= 1'b1;                    // other master sends its stop
        wait_idle_bus();

        $display("errors %0d, timeouts %0d, assertion failures %0d",
                 err_cnt, timeout_cnt, i_i2c_bit_ctrl.i_chk.assert_fail_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && i_i2c_bit_ctrl.i_chk.assert_fail_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // overall guard on simulation time
    initial begin
        #2000000;
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/i2c_bit_ctrl.sv
// I2C master bit controller, open-drain enables only (0 pulls the line low)
// multi-master safe; no slave mode
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl
    import i2c_bit_pkg::*;
#(
    parameter int PRESCALE_W = i2c_bit_pkg::PRESCALE_W
) (
    input  logic                  clk,
    input  logic                  nReset,
    input  logic                  ena,      // core enable
    input  logic [PRESCALE_W-1:0] clk_cnt,  // phase length minus one
    input  i2c_cmd_t              cmd,
    input  logic                  din,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  cmd_ack,
    output logic                  busy,
    output logic                  al,
    output logic                  dout,
    output logic                  scl_oen,
    output logic                  sda_oen
);

    logic scl_f, sda_f;         // filtered lines
    logic scl_d, sda_d;         // and their delayed copies
    logic sto_cond;
    logic clk_en;

    i2c_line_filter #(
        .PRESCALE_W (PRESCALE_W)
    ) i_line_filter (
        .clk     (clk),
        .nReset  (nReset),
        .ena     (ena),
        .clk_cnt (clk_cnt),
        .scl_i   (scl_i),
        .sda_i   (sda_i),
        .scl_f   (scl_f),
        .sda_f   (sda_f),
        .scl_d   (scl_d),
        .sda_d   (sda_d)
    );

    i2c_bus_monitor i_bus_monitor (
        .clk      (clk),
        .nReset   (nReset),
        .scl_f    (scl_f),
        .sda_f    (sda_f),
        .scl_d    (scl_d),
        .sda_d    (sda_d),
        .sta_cond (),           // start pulse only feeds busy here
        .sto_cond (sto_cond),
        .busy     (busy),
        .dout     (dout)
    );

    i2c_scl_timer #(
        .PRESCALE_W (PRESCALE_W)
    ) i_scl_timer (
        .clk     (clk),
        .nReset  (nReset),
        .ena     (ena),
        .clk_cnt (clk_cnt),
        .scl_f   (scl_f),
        .scl_d   (scl_d),
        .scl_oen (scl_oen),
        .clk_en  (clk_en)
    );

    i2c_bit_sequencer i_bit_sequencer (
        .clk      (clk),
        .nReset   (nReset),
        .cmd      (cmd),
        .din      (din),
        .clk_en   (clk_en),
        .sda_f    (sda_f),
        .sto_cond (sto_cond),
        .scl_oen  (scl_oen),
        .sda_oen  (sda_oen),
        .cmd_ack  (cmd_ack),
        .al       (al)
    );

endmodule

`default_nettype wire

//--- design/i2c_bit_pkg.sv
// command encoding and width constants for the I2C master bit controller
// command codes keep the one-hot style of the byte controller interface
`default_nettype none

package i2c_bit_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bit commands
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        CMD_NOP   = 4'b0000,    // nothing, stay idle
        CMD_START = 4'b0001,    // start or repeated start
        CMD_STOP  = 4'b0010,
        CMD_WRITE = 4'b0100,    // drive din for one bit
        CMD_READ  = 4'b1000     // release sda, sample on scl rise
    } i2c_cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    parameter int PRESCALE_W   = 16;  // default prescale counter width
    parameter int FILTER_SHIFT = 2;   // filter samples at prescale / 4
    parameter int FILTER_TAPS  = 3;   // majority window length

endpackage

`default_nettype wire

//--- design/i2c_bit_sequencer.sv
// phase FSM turning one bit command into scl/sda enables (0 pulls the line low)
// host holds cmd until cmd_ack; al aborts the command without an ack
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_sequencer
    import i2c_bit_pkg::*;
(
    input  logic     clk,
    input  logic     nReset,
    input  i2c_cmd_t cmd,       // held until cmd_ack
    input  logic     din,       // bit to write
    input  logic     clk_en,    // phase enable
    input  logic     sda_f,     // filtered sda
    input  logic     sto_cond,  // stop seen on the bus
    output logic     scl_oen,
    output logic     sda_oen,
    output logic     cmd_ack,   // one clock on the last phase
    output logic     al         // arbitration lost
);

    typedef enum logic [4:0] {
        ST_IDLE,
        START_A, START_B, START_C, START_D, START_E,
        STOP_A, STOP_B, STOP_C, STOP_D,
        RD_A, RD_B, RD_C, RD_D,
        WR_A, WR_B, WR_C, WR_D
    } state_t;

    state_t state;
    logic   sda_chk;   // compare sda with what we drive
    logic   cmd_stop;  // current command is a stop

    ////////////////////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            cmd_stop <= 1'b0;
            al       <= 1'b0;
        end else begin
            if (clk_en)
                cmd_stop <= (cmd == CMD_STOP);
            // released sda reads low, or a stop we did not ask for
            al <= (sda_chk & ~sda_f & sda_oen) |
                  ((state != ST_IDLE) & sto_cond & ~cmd_stop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            state   <= ST_IDLE;
            cmd_ack <= 1'b0;
            scl_oen <= 1'b1;
            sda_oen <= 1'b1;
            sda_chk <= 1'b0;
        end else if (al) begin              // lost the bus, back off
            state   <= ST_IDLE;
            cmd_ack <= 1'b0;
            scl_oen <= 1'b1;
            sda_oen <= 1'b1;
            sda_chk <= 1'b0;
        end else begin
            cmd_ack <= 1'b0;
            if (clk_en) begin
                sda_chk <= 1'b0;            // only wr_c checks
                unique case (state)
                    ST_IDLE: begin          // enables keep their level
                        unique case (cmd)
                            CMD_START: state <= START_A;
                            CMD_STOP:  state <= STOP_A;
                            CMD_WRITE: state <= WR_A;
                            CMD_READ:  state <= RD_A;
                            default:   state <= ST_IDLE;
                        endcase
                    end

                    // start or repeated start
                    START_A: begin
                        state   <= START_B;
                        sda_oen <= 1'b1;
                    end
                    START_B: begin
                        state   <= START_C;
                        scl_oen <= 1'b1;
                    end
                    START_C: begin
                        state   <= START_D;
                        sda_oen <= 1'b0;    // sda falls, scl high
                    end
                    START_D: state <= START_E;
                    START_E: begin
                        state   <= ST_IDLE;
                        cmd_ack <= 1'b1;
                        scl_oen <= 1'b0;
                    end

                    // stop
                    STOP_A: begin
                        state   <= STOP_B;
                        scl_oen <= 1'b0;
                        sda_oen <= 1'b0;
                    end
                    STOP_B: begin
                        state   <= STOP_C;
                        scl_oen <= 1'b1;
                    end
                    STOP_C: state <= STOP_D;
                    STOP_D: begin
                        state   <= ST_IDLE;
                        cmd_ack <= 1'b1;
                        sda_oen <= 1'b1;    // sda rises, scl high
                    end

                    // read keeps sda released throughout
                    RD_A: begin
                        state   <= RD_B;
                        scl_oen <= 1'b0;
                        sda_oen <= 1'b1;
                    end
                    RD_B: begin
                        state   <= RD_C;
                        scl_oen <= 1'b1;
                    end
                    RD_C: state <= RD_D;
                    RD_D: begin
                        state   <= ST_IDLE;
                        cmd_ack <= 1'b1;
                        scl_oen <= 1'b0;
                    end

                    // write holds din on sda for the whole bit
                    WR_A: begin
                        state   <= WR_B;
                        scl_oen <= 1'b0;
                        sda_oen <= din;
                    end
                    WR_B: begin
                        state   <= WR_C;
                        scl_oen <= 1'b1;    // give sda time to settle first
                        sda_oen <= din;
                    end
                    WR_C: begin
                        state   <= WR_D;
                        sda_oen <= din;
                        sda_chk <= 1'b1;
                    end
                    WR_D: begin
                        state   <= ST_IDLE;
                        cmd_ack <= 1'b1;
                        scl_oen <= 1'b0;
                        sda_oen <= din;
                    end

                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_bus_monitor.sv
// start/stop detection and busy flag on the filtered lines
// dout has no reset and is valid only after the first scl rise
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_monitor (
    input  logic clk,
    input  logic nReset,
    input  logic scl_f,     // filtered levels
    input  logic sda_f,
    input  logic scl_d,     // filtered levels, one clock late
    input  logic sda_d,
    output logic sta_cond,  // one clock pulse per start
    output logic sto_cond,  // one clock pulse per stop
    output logic busy,      // between start and stop
    output logic dout       // sda at last scl rise
);

    // sda falls while scl high -> start
    // sda rises while scl high -> stop
    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            sta_cond <= 1'b0;
            sto_cond <= 1'b0;
            busy     <= 1'b0;
        end else begin
            sta_cond <= ~sda_f & sda_d & scl_f;
            sto_cond <= sda_f & ~sda_d & scl_f;
            busy     <= (sta_cond | busy) & ~sto_cond;  // stop wins over start
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read bit capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (scl_f && !scl_d)                // scl rising edge
            dout <= sda_f;
    end

endmodule

`default_nettype wire

//--- design/i2c_line_filter.sv
// synchronizes and glitch filters scl and sda; both lines read high out of reset
// sample rate follows clk_cnt, so a zero prescale samples every clock
`timescale 1ns/1ps
`default_nettype none

module i2c_line_filter
    import i2c_bit_pkg::*;
#(
    parameter int PRESCALE_W = i2c_bit_pkg::PRESCALE_W
) (
    input  logic                  clk,
    input  logic                  nReset,
    input  logic                  ena,      // low holds the sample counter at zero
    input  logic [PRESCALE_W-1:0] clk_cnt,  // prescale value
    input  logic                  scl_i,    // raw bus levels
    input  logic                  sda_i,
    output logic                  scl_f,    // filtered levels
    output logic                  sda_f,
    output logic                  scl_d,    // filtered, one clock later
    output logic                  sda_d
);

    localparam int CNT_W = PRESCALE_W - FILTER_SHIFT;

    logic                   scl_s1, scl_s2;       // two flop synchronizers
    logic                   sda_s1, sda_s2;
    logic [CNT_W-1:0]       filter_cnt;           // sample interval counter
    logic [FILTER_TAPS-1:0] scl_win, sda_win;     // sample windows

    // more than half the taps high
    function automatic logic majority(input logic [FILTER_TAPS-1:0] win);
        int ones;
        ones = 0;
        for (int i = 0; i < FILTER_TAPS; i++)
            ones += int'(win[i]);
        return ones > FILTER_TAPS / 2;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // synchronize, then sample at a quarter of the prescale period
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            scl_s1     <= 1'b1;
            scl_s2     <= 1'b1;
            sda_s1     <= 1'b1;
            sda_s2     <= 1'b1;
            filter_cnt <= '0;
            scl_win    <= '1;                     // idle bus is high
            sda_win    <= '1;
        end else begin
            scl_s1 <= scl_i;
            scl_s2 <= scl_s1;
            sda_s1 <= sda_i;
            sda_s2 <= sda_s1;

            if (!ena)
                filter_cnt <= '0;
            else if (filter_cnt == '0)
                filter_cnt <= clk_cnt[PRESCALE_W-1:FILTER_SHIFT];
            else
                filter_cnt <= filter_cnt - 1'b1;

            if (filter_cnt == '0) begin           // sample tick
                scl_win <= {scl_win[FILTER_TAPS-2:0], scl_s2};
                sda_win <= {sda_win[FILTER_TAPS-2:0], sda_s2};
            end
        end
    end

    // registered vote plus delayed copy for edge detection
    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            scl_f <= 1'b1;
            sda_f <= 1'b1;
            scl_d <= 1'b1;
            sda_d <= 1'b1;
        end else begin
            scl_f <= majority(scl_win);
            sda_f <= majority(sda_win);
            scl_d <= scl_f;
            sda_d <= sda_f;
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_scl_timer.sv
// phase enable generator; clk_en pulses once per clk_cnt+1 clocks
// freezes while a target stretches scl, reloads when another master pulls scl low
`timescale 1ns/1ps
`default_nettype none

module i2c_scl_timer #(
    parameter int PRESCALE_W = i2c_bit_pkg::PRESCALE_W
) (
    input  logic                  clk,
    input  logic                  nReset,
    input  logic                  ena,      // low keeps the counter in reload
    input  logic [PRESCALE_W-1:0] clk_cnt,  // prescale value
    input  logic                  scl_f,    // filtered scl
    input  logic                  scl_d,    // filtered scl, one clock late
    input  logic                  scl_oen,  // our own scl enable
    output logic                  clk_en    // single cycle phase pulse
);

    logic [PRESCALE_W-1:0] cnt;
    logic                  dscl_oen;  // scl_oen one clock late
    logic                  stretch;   // released scl still reads low
    logic                  scl_sync;

    // another master pulls a high scl low while we release it
    assign scl_sync = scl_d & ~scl_f & scl_oen;

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            dscl_oen <= 1'b1;
            stretch  <= 1'b0;
        end else begin
            dscl_oen <= scl_oen;
            // set on release while low, held until scl reads high
            stretch  <= (scl_oen & ~dscl_oen & ~scl_f) | (stretch & ~scl_f);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // prescale down-counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            cnt    <= '0;
            clk_en <= 1'b1;
        end else if (cnt == '0 || !ena || scl_sync) begin
            cnt    <= clk_cnt;
            clk_en <= 1'b1;
        end else if (stretch) begin
            clk_en <= 1'b0;                 // count frozen
        end else begin
            cnt    <= cnt - 1'b1;
            clk_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
design/i2c_bit_pkg.sv
design/i2c_line_filter.sv
design/i2c_bus_monitor.sv
design/i2c_scl_timer.sv
design/i2c_bit_sequencer.sv
design/i2c_bit_ctrl.sv
bench/i2c_bit_ctrl_chk.sv
bench/tb_i2c_bit_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, fail on the fail message or a bad exit
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_i2c_bit_ctrl \
    -f filelist.f -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "\*\* FAIL \*\*" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log && echo "test passed" || { echo "no verdict in sim.log"; exit 1; }
